// ==== source/weapon_cfg.svh ====
// Weapon sizes, placement offsets, swing steps and colours as macros
`default_nettype none

`ifndef WEAPON_CFG_SVH
`define WEAPON_CFG_SVH

// ----------------------------------------------------------
// Sprite rectangles
// ----------------------------------------------------------
// Blade box in pixels
`define MELEE_W       12'd54
`define MELEE_H       12'd28
// Bow box in pixels
`define ARCHER_W      12'd40
`define ARCHER_H      12'd31

// ----------------------------------------------------------
// Placement relative to the player
// ----------------------------------------------------------
// Horizontal gap between player origin and weapon
`define MELEE_OFS_X   12'd20
`define ARCHER_OFS_X  12'd16
// Drop from player top, shared by both weapons
`define WEAPON_OFS_Y  12'd24

// ----------------------------------------------------------
// Swing animation and colours
// ----------------------------------------------------------
// Pixels per frame, peak is a whole number of steps
`define SWING_STEP    12'sd4
`define SWING_MAX     12'sd16
// 4:4:4 fill colours
`define MELEE_RGB     12'hBCD
`define ARCHER_RGB    12'h852

`endif

`default_nettype wire

// ==== source/weapon_pkg.sv ====
// Weapon layer types: vector typedefs, game and swing enums, stream structs
`default_nettype none

package weapon_pkg;

    // ----------------------------------------------------------
    // Plain vectors
    // ----------------------------------------------------------
    // Screen position in pixels
    typedef logic [11:0] coord_t;
    // 4:4:4 colour
    typedef logic [11:0] rgb_t;
    // Signed horizontal swing shift
    typedef logic signed [11:0] offset_t;

    // ----------------------------------------------------------
    // Enums
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        GAME_MENU = 2'd0,
        GAME_PLAY = 2'd1,
        GAME_OVER = 2'd2
    } game_state_t;

    typedef enum logic [1:0] {
        CLASS_MELEE  = 2'd0,
        CLASS_ARCHER = 2'd1
    } char_class_t;

    // Blade animation phases
    typedef enum logic [1:0] {
        SWING_IDLE = 2'd0,
        SWING_OUT  = 2'd1,
        SWING_BACK = 2'd2
    } swing_state_t;

    // ----------------------------------------------------------
    // Structs
    // ----------------------------------------------------------
    // One pixel of the VGA stream with its timing
    typedef struct packed {
        coord_t hcount;
        coord_t vcount;
        logic   hsync;
        logic   vsync;
        logic   hblnk;
        logic   vblnk;
        rgb_t   rgb;
    } vga_t;

    // Top-left corner of a weapon, flip when facing left
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   flip;
    } anchor_t;

    // Coverage and colour of one weapon at one pixel
    typedef struct packed {
        logic on;
        rgb_t rgb;
    } weapon_px_t;

endpackage

`default_nettype wire

// ==== source/weapon_position.sv ====
// Weapon facing and top-left anchors, updated once per frame
`include "weapon_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module weapon_position (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                frame_tick,
    input  weapon_pkg::coord_t  pos_x,
    input  weapon_pkg::coord_t  pos_y,
    input  weapon_pkg::coord_t  mouse_x,
    output weapon_pkg::anchor_t melee_anchor,
    output weapon_pkg::anchor_t archer_anchor
);
    import weapon_pkg::*;

    // ----------------------------------------------------------
    // Candidate positions for the current inputs
    // ----------------------------------------------------------
    logic   face_left;
    coord_t weapon_y;
    coord_t melee_x;
    coord_t archer_x;

    always_comb begin
        // Mouse left of the player turns the weapons around
        face_left = (mouse_x < pos_x);
        weapon_y  = pos_y + `WEAPON_OFS_Y;

        // Mirrored placement keeps the same gap on the left side
        if (face_left) begin
            melee_x  = pos_x - `MELEE_OFS_X - `MELEE_W;
            archer_x = pos_x - `ARCHER_OFS_X - `ARCHER_W;
        end else begin
            melee_x  = pos_x + `MELEE_OFS_X;
            archer_x = pos_x + `ARCHER_OFS_X;
        end
    end

    // ----------------------------------------------------------
    // Anchor registers
    // ----------------------------------------------------------
    // Sampled on frame_tick only, so a frame is never torn
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            melee_anchor  <= '0;
            archer_anchor <= '0;
        end else if (frame_tick) begin
            melee_anchor.x     <= melee_x;
            melee_anchor.y     <= weapon_y;
            melee_anchor.flip  <= face_left;

            archer_anchor.x    <= archer_x;
            archer_anchor.y    <= weapon_y;
            archer_anchor.flip <= face_left;
        end
    end

endmodule

`default_nettype wire

// ==== source/melee_swing.sv ====
// Melee swing FSM with per-frame blade offset and boss hit detection
`include "weapon_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module melee_swing (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     frame_tick,
    input  logic                     mouse_clicked,
    input  logic                     alive,
    input  logic                     boss_alive,
    input  weapon_pkg::game_state_t  game,
    input  weapon_pkg::char_class_t  char_class,
    input  weapon_pkg::anchor_t      melee_anchor,
    input  weapon_pkg::coord_t       boss_x,
    input  weapon_pkg::coord_t       boss_y,
    output weapon_pkg::offset_t      swing_dx,
    output logic                     melee_hit
);
    import weapon_pkg::*;

    swing_state_t state;
    logic         req_pending;
    logic         click_ok;
    offset_t      dx_next;
    logic         at_peak;
    coord_t       span_lo;
    coord_t       span_hi;
    coord_t       row_hi;
    logic         boss_in_span;

    // ----------------------------------------------------------
    // Next offset and hit geometry
    // ----------------------------------------------------------
    always_comb begin
        // Clicks only count for a living melee player at rest
        click_ok = mouse_clicked && alive && (state == SWING_IDLE) &&
                   (game == GAME_PLAY) && (char_class == CLASS_MELEE);

        case (state)
            SWING_OUT:  dx_next = swing_dx + `SWING_STEP;
            SWING_BACK: dx_next = swing_dx - `SWING_STEP;
            default:    dx_next = swing_dx;
        endcase

        // Tick on which the blade lands at full reach
        at_peak = frame_tick && (state == SWING_OUT) && (dx_next == `SWING_MAX);

        // Swept area covers every blade position of the swing
        span_lo = melee_anchor.flip ? melee_anchor.x - coord_t'(`SWING_MAX) : melee_anchor.x;
        span_hi = span_lo + `MELEE_W + coord_t'(`SWING_MAX);
        row_hi  = melee_anchor.y + `MELEE_H;

        boss_in_span = (boss_x >= span_lo) && (boss_x < span_hi) &&
                       (boss_y >= melee_anchor.y) && (boss_y < row_hi);
    end

    // ----------------------------------------------------------
    // Swing FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= SWING_IDLE;
            swing_dx    <= '0;
            req_pending <= 1'b0;
            melee_hit   <= 1'b0;
        end else begin
            // Single-cycle pulse
            melee_hit <= at_peak && boss_alive && boss_in_span;

            if (click_ok)
                req_pending <= 1'b1;

            if (frame_tick) begin
                case (state)
                    SWING_IDLE: begin
                        // Pending click starts the swing at the frame boundary
                        if (req_pending) begin
                            state       <= SWING_OUT;
                            req_pending <= 1'b0;
                        end
                    end
                    SWING_OUT: begin
                        swing_dx <= dx_next;
                        if (dx_next == `SWING_MAX)
                            state <= SWING_BACK;
                    end
                    SWING_BACK: begin
                        swing_dx <= dx_next;
                        if (dx_next == '0)
                            state <= SWING_IDLE;
                    end
                    default: state <= SWING_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/melee_draw.sv ====
// Per-pixel blade coverage with the swing offset applied
`include "weapon_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module melee_draw (
    input  logic                   clk,
    input  logic                   rst_n,
    input  weapon_pkg::vga_t       vga_in,
    input  weapon_pkg::anchor_t    melee_anchor,
    input  weapon_pkg::offset_t    swing_dx,
    output weapon_pkg::weapon_px_t melee_px
);
    import weapon_pkg::*;

    coord_t blade_x;
    coord_t blade_x_end;
    coord_t blade_y_end;
    logic   in_cols;
    logic   in_rows;

    // ----------------------------------------------------------
    // Blade rectangle for this frame
    // ----------------------------------------------------------
    always_comb begin
        // Swing pushes the blade away from the player
        if (melee_anchor.flip)
            blade_x = melee_anchor.x - coord_t'(swing_dx);
        else
            blade_x = melee_anchor.x + coord_t'(swing_dx);

        blade_x_end = blade_x + `MELEE_W;
        blade_y_end = melee_anchor.y + `MELEE_H;

        // Half-open ranges in both axes
        in_cols = (vga_in.hcount >= blade_x) && (vga_in.hcount < blade_x_end);
        in_rows = (vga_in.vcount >= melee_anchor.y) && (vga_in.vcount < blade_y_end);
    end

    // ----------------------------------------------------------
    // Output pixel register
    // ----------------------------------------------------------
    // One cycle behind vga_in
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            melee_px <= '0;
        end else begin
            melee_px.on  <= in_cols && in_rows;
            melee_px.rgb <= `MELEE_RGB;
        end
    end

endmodule

`default_nettype wire

// ==== source/archer_draw.sv ====
// Per-pixel bow coverage at the archer anchor
`include "weapon_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module archer_draw (
    input  logic                   clk,
    input  logic                   rst_n,
    input  weapon_pkg::vga_t       vga_in,
    input  weapon_pkg::anchor_t    archer_anchor,
    output weapon_pkg::weapon_px_t archer_px
);
    import weapon_pkg::*;

    coord_t bow_x_end;
    coord_t bow_y_end;
    logic   in_cols;
    logic   in_rows;

    // ----------------------------------------------------------
    // Bow rectangle
    // ----------------------------------------------------------
    // Facing already folded into anchor x
    always_comb begin
        bow_x_end = archer_anchor.x + `ARCHER_W;
        bow_y_end = archer_anchor.y + `ARCHER_H;

        in_cols = (vga_in.hcount >= archer_anchor.x) && (vga_in.hcount < bow_x_end);
        in_rows = (vga_in.vcount >= archer_anchor.y) && (vga_in.vcount < bow_y_end);
    end

    // ----------------------------------------------------------
    // Output pixel register
    // ----------------------------------------------------------
    // Same latency as the blade path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            archer_px <= '0;
        end else begin
            archer_px.on  <= in_cols && in_rows;
            archer_px.rgb <= `ARCHER_RGB;
        end
    end

endmodule

`default_nettype wire

// ==== source/weapon_overlay.sv ====
// Stream alignment and merge of the active class weapon pixel
`timescale 1ns/1ps
`default_nettype none

module weapon_overlay (
    input  logic                    clk,
    input  logic                    rst_n,
    input  weapon_pkg::vga_t        vga_in,
    input  weapon_pkg::weapon_px_t  melee_px,
    input  weapon_pkg::weapon_px_t  archer_px,
    input  weapon_pkg::char_class_t char_class,
    input  weapon_pkg::game_state_t game,
    input  logic                    alive,
    output weapon_pkg::vga_t        vga_out
);
    import weapon_pkg::*;

    vga_t       vga_d;
    weapon_px_t sel_px;
    logic       paint;

    // ----------------------------------------------------------
    // Stage 1: line up with the registered weapon pixels
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n)
            vga_d <= '0;
        else
            vga_d <= vga_in;
    end

    // Class picks the path, the other is ignored
    always_comb begin
        sel_px = (char_class == CLASS_MELEE) ? melee_px : archer_px;
        // Blanking and inactive play always pass through
        paint  = sel_px.on && alive && (game == GAME_PLAY) &&
                 !vga_d.hblnk && !vga_d.vblnk;
    end

    // ----------------------------------------------------------
    // Stage 2: registered output
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vga_out <= '0;
        end else begin
            vga_out <= vga_d;
            if (paint)
                vga_out.rgb <= sel_px.rgb;
        end
    end

endmodule

`default_nettype wire

// ==== source/weapon_top.sv ====
// Weapon layer top: positioning, melee swing, both draw paths and overlay
`timescale 1ns/1ps
`default_nettype none

module weapon_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    frame_tick,
    input  logic                    mouse_clicked,
    input  logic                    alive,
    input  logic                    boss_alive,
    input  weapon_pkg::coord_t      pos_x,
    input  weapon_pkg::coord_t      pos_y,
    input  weapon_pkg::coord_t      mouse_x,
    input  weapon_pkg::coord_t      boss_x,
    input  weapon_pkg::coord_t      boss_y,
    input  weapon_pkg::game_state_t game,
    input  weapon_pkg::char_class_t char_class,
    input  weapon_pkg::vga_t        vga_in,
    output weapon_pkg::vga_t        vga_out,
    output logic                    melee_hit
);
    import weapon_pkg::*;

    anchor_t    melee_anchor;
    anchor_t    archer_anchor;
    offset_t    swing_dx;
    weapon_px_t melee_px;
    weapon_px_t archer_px;

    // ----------------------------------------------------------
    // Placement and melee animation
    // ----------------------------------------------------------
    weapon_position u_weapon_position (
        .clk, .rst_n, .frame_tick,
        .pos_x, .pos_y, .mouse_x,
        .melee_anchor, .archer_anchor
    );

    melee_swing u_melee_swing (
        .clk, .rst_n, .frame_tick, .mouse_clicked,
        .alive, .boss_alive, .game, .char_class,
        .melee_anchor, .boss_x, .boss_y,
        .swing_dx, .melee_hit
    );

    // ----------------------------------------------------------
    // Parallel draw paths feeding the overlay
    // ----------------------------------------------------------
    melee_draw u_melee_draw (
        .clk, .rst_n, .vga_in,
        .melee_anchor, .swing_dx, .melee_px
    );

    archer_draw u_archer_draw (
        .clk, .rst_n, .vga_in,
        .archer_anchor, .archer_px
    );

    weapon_overlay u_weapon_overlay (
        .clk, .rst_n, .vga_in,
        .melee_px, .archer_px,
        .char_class, .game, .alive,
        .vga_out
    );

endmodule

`default_nettype wire

// ==== test/weapon_top_tb.sv ====
// Table-driven testbench for the weapon layer with a synthetic frame and reference model
`include "weapon_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module weapon_top_tb;
    import weapon_pkg::*;

    // 128x64 visible window, blank margin right and below
    localparam int H_TOTAL   = 136;
    localparam int V_TOTAL   = 68;
    localparam int FRAME_LEN = H_TOTAL * V_TOTAL;
    localparam int NUM_ROWS  = 10;

    // One scenario of the stimulus table
    typedef struct packed {
        coord_t      pos_x;
        coord_t      pos_y;
        coord_t      mouse_x;
        char_class_t char_class;
        game_state_t game;
        logic        alive;
        logic        click;
        coord_t      boss_x;
        coord_t      boss_y;
        logic        boss_alive;
        int          frames;
        logic        hit;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        frame_tick;
    logic        mouse_clicked;
    logic        alive;
    logic        boss_alive;
    coord_t      pos_x;
    coord_t      pos_y;
    coord_t      mouse_x;
    coord_t      boss_x;
    coord_t      boss_y;
    game_state_t game;
    char_class_t char_class;
    vga_t        vga_in;
    vga_t        vga_out;
    logic        melee_hit;

    row_t         tbl [NUM_ROWS];
    vga_t         exp_q[$];
    anchor_t      m_anchor;
    anchor_t      a_anchor;
    swing_state_t m_state;
    offset_t      m_dx;
    logic         m_pending;
    logic         hit_due;
    int           hit_count;
    int           cycles = 0;
    int           cycle_limit = 0;

    weapon_top weapon_top_i (
        .clk, .rst_n, .frame_tick, .mouse_clicked, .alive, .boss_alive,
        .pos_x, .pos_y, .mouse_x, .boss_x, .boss_y, .game, .char_class,
        .vga_in, .vga_out, .melee_hit
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles without finishing the table", cycles);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input logic [40:0] got, input logic [40:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic logic in_rect(input vga_t px, input coord_t x, input coord_t y,
                                     input coord_t w, input coord_t h);
        return (px.hcount >= x) && (px.hcount < x + w) &&
               (px.vcount >= y) && (px.vcount < y + h);
    endfunction

    function automatic vga_t expected_out(input vga_t px, input row_t rw);
        vga_t   res;
        coord_t bx;
        logic   on;
        res = px;
        // Blade pushed away from the player by the swing
        bx = m_anchor.flip ? m_anchor.x - coord_t'(m_dx) : m_anchor.x + coord_t'(m_dx);
        if (rw.char_class == CLASS_MELEE)
            on = in_rect(px, bx, m_anchor.y, `MELEE_W, `MELEE_H);
        else
            on = in_rect(px, a_anchor.x, a_anchor.y, `ARCHER_W, `ARCHER_H);
        if (on && rw.alive && rw.game == GAME_PLAY && !px.hblnk && !px.vblnk)
            res.rgb = (rw.char_class == CLASS_MELEE) ? `MELEE_RGB : `ARCHER_RGB;
        return res;
    endfunction

    // Swing first since the hit test sees the anchor of the ending frame
    task automatic frame_update(input row_t rw);
        logic   left;
        coord_t span_lo;
        case (m_state)
            SWING_IDLE: begin
                if (m_pending) begin
                    m_state   = SWING_OUT;
                    m_pending = 1'b0;
                end
            end
            SWING_OUT: begin
                m_dx = m_dx + `SWING_STEP;
                if (m_dx == `SWING_MAX) begin
                    m_state = SWING_BACK;
                    span_lo = m_anchor.flip ? m_anchor.x - coord_t'(`SWING_MAX) : m_anchor.x;
                    hit_due = rw.boss_alive && (rw.boss_x >= span_lo) &&
                              (rw.boss_x < span_lo + `MELEE_W + coord_t'(`SWING_MAX)) &&
                              (rw.boss_y >= m_anchor.y) && (rw.boss_y < m_anchor.y + `MELEE_H);
                end
            end
            SWING_BACK: begin
                m_dx = m_dx - `SWING_STEP;
                if (m_dx == '0)
                    m_state = SWING_IDLE;
            end
            default: m_state = SWING_IDLE;
        endcase

        left          = rw.mouse_x < rw.pos_x;
        m_anchor.flip = left;
        a_anchor.flip = left;
        m_anchor.y    = rw.pos_y + `WEAPON_OFS_Y;
        a_anchor.y    = rw.pos_y + `WEAPON_OFS_Y;
        m_anchor.x    = left ? rw.pos_x - `MELEE_OFS_X - `MELEE_W : rw.pos_x + `MELEE_OFS_X;
        a_anchor.x    = left ? rw.pos_x - `ARCHER_OFS_X - `ARCHER_W : rw.pos_x + `ARCHER_OFS_X;
    endtask

    // ----------------------------------------------------------
    // Scenario table and main sequence
    // ----------------------------------------------------------
    initial begin
        void'($urandom(4734));
        // pos_x pos_y mouse_x class game alive click boss_x boss_y boss_alive frames hit
        tbl[0] = '{12'd30, 12'd10, 12'd100, CLASS_MELEE, GAME_MENU, 1'b1, 1'b0,
                   12'd60, 12'd40, 1'b1, 2, 1'b0};
        // Blade reaches into both blank margins
        tbl[1] = '{12'd80, 12'd30, 12'd100, CLASS_MELEE, GAME_PLAY, 1'b1, 1'b0,
                   12'd60, 12'd40, 1'b1, 2, 1'b0};
        tbl[2] = '{12'd100, 12'd10, 12'd20, CLASS_MELEE, GAME_PLAY, 1'b1, 1'b0,
                   12'd60, 12'd40, 1'b1, 2, 1'b0};
        tbl[3] = '{12'd30, 12'd10, 12'd100, CLASS_ARCHER, GAME_PLAY, 1'b1, 1'b1,
                   12'd60, 12'd40, 1'b1, 3, 1'b0};
        tbl[4] = '{12'd100, 12'd10, 12'd20, CLASS_ARCHER, GAME_PLAY, 1'b1, 1'b0,
                   12'd60, 12'd40, 1'b1, 2, 1'b0};
        tbl[5] = '{12'd30, 12'd10, 12'd100, CLASS_MELEE, GAME_PLAY, 1'b0, 1'b1,
                   12'd60, 12'd40, 1'b1, 2, 1'b0};
        tbl[6] = '{12'd30, 12'd10, 12'd100, CLASS_MELEE, GAME_OVER, 1'b1, 1'b1,
                   12'd60, 12'd40, 1'b1, 2, 1'b0};
        // Swings: boss inside, outside, inside but dead
        tbl[7] = '{12'd30, 12'd10, 12'd100, CLASS_MELEE, GAME_PLAY, 1'b1, 1'b1,
                   12'd60, 12'd40, 1'b1, 10, 1'b1};
        tbl[8] = '{12'd100, 12'd10, 12'd20, CLASS_MELEE, GAME_PLAY, 1'b1, 1'b1,
                   12'd120, 12'd40, 1'b1, 10, 1'b0};
        tbl[9] = '{12'd30, 12'd10, 12'd100, CLASS_MELEE, GAME_PLAY, 1'b1, 1'b1,
                   12'd60, 12'd40, 1'b0, 10, 1'b0};

        rst_n = 1'b0;
        frame_tick = 1'b0;
        mouse_clicked = 1'b0;
        alive = 1'b0;
        boss_alive = 1'b0;
        pos_x = '0;
        pos_y = '0;
        mouse_x = '0;
        boss_x = '0;
        boss_y = '0;
        game = GAME_MENU;
        char_class = CLASS_MELEE;
        vga_in = '0;
        m_anchor = '0;
        a_anchor = '0;
        m_state = SWING_IDLE;
        m_dx = '0;
        m_pending = 1'b0;
        hit_due = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++)
            cycle_limit += tbl[r].frames * FRAME_LEN;
        cycle_limit += 1000;

        repeat (8) @(negedge clk);
        check("vga_out", vga_out, '0);
        check("melee_hit", 41'(melee_hit), '0);
        rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            hit_count = 0;
            for (int f = 0; f < tbl[r].frames; f++) begin
                for (int v = 0; v < V_TOTAL; v++) begin
                    for (int h = 0; h < H_TOTAL; h++) begin
                        @(negedge clk);
                        check("melee_hit", 41'(melee_hit), 41'(hit_due));
                        hit_due = 1'b0;
                        if (melee_hit)
                            hit_count++;
                        // Output lags the input by two cycles
                        if (exp_q.size() == 2)
                            check("vga_out", vga_out, exp_q.pop_front());

                        pos_x = tbl[r].pos_x;
                        pos_y = tbl[r].pos_y;
                        mouse_x = tbl[r].mouse_x;
                        char_class = tbl[r].char_class;
                        game = tbl[r].game;
                        alive = tbl[r].alive;
                        boss_x = tbl[r].boss_x;
                        boss_y = tbl[r].boss_y;
                        boss_alive = tbl[r].boss_alive;
                        frame_tick = (h == H_TOTAL - 1) && (v == V_TOTAL - 1);
                        // Second click lands mid-swing and must be ignored
                        mouse_clicked = tbl[r].click && (v == 0) && (h == 5) &&
                                        (f == 0 || f == 2);
                        vga_in.hcount = coord_t'(h);
                        vga_in.vcount = coord_t'(v);
                        vga_in.hsync = (h >= 130) && (h < 133);
                        vga_in.vsync = (v == 65);
                        vga_in.hblnk = (h >= 128);
                        vga_in.vblnk = (v >= 64);
                        vga_in.rgb = rgb_t'($urandom);

                        exp_q.push_back(expected_out(vga_in, tbl[r]));
                        if (mouse_clicked && alive && m_state == SWING_IDLE &&
                            game == GAME_PLAY && char_class == CLASS_MELEE)
                            m_pending = 1'b1;
                        if (frame_tick)
                            frame_update(tbl[r]);
                    end
                end
            end
            check("hit_count", 41'(hit_count), 41'(tbl[r].hit));
        end

        // Drain the pixels still in flight
        frame_tick = 1'b0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            check("vga_out", vga_out, exp_q.pop_front());
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/weapon_pkg.sv
source/weapon_position.sv
source/melee_swing.sv
source/melee_draw.sv
source/archer_draw.sv
source/weapon_overlay.sv
source/weapon_top.sv
test/weapon_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the weapon layer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f tb.f --top-module weapon_top_tb -o sim_weapon
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_weapon)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    exit 1
fi

if echo "$out" | grep -q "Simulation passed"; then
    exit 0
fi
exit 1
